/* flist.f */
logic/dg_timing_pkg.sv
logic/dg_regs_pkg.sv
logic/dg_host_port.sv
logic/dg_protocol_table.sv
logic/dg_pulse_channel.sv
logic/dg_sequencer.sv
logic/dg_top.sv
testbench/dg_checker.sv
testbench/dg_tb.sv

/* logic/dg_host_port.sv */
// host register decoder: page writes, protocol selection, interval commit
`timescale 1ns/1ps

module dg_host_port (
   input  logic                                     clk100,
   input  logic                                     hps_fpga_reset_n,
   input  logic                                     host_write,
   input  dg_regs_pkg::reg_addr_e                   host_addr,
   input  logic [dg_regs_pkg::HOST_DATA_WIDTH-1:0]  host_data,
   output logic                                     pair_write,
   output logic [dg_timing_pkg::PAGE_WIDTH-1:0]     pair_page,
   output logic [dg_regs_pkg::ADDR_WIDTH-1:0]       pair_index,
   output dg_timing_pkg::delay_width_t              pair_value,
   output logic [dg_timing_pkg::PAGE_WIDTH-1:0]     protocol_select,
   output logic                                     interval_commit,
   output logic [dg_timing_pkg::TIME_WIDTH-1:0]     interval_value
);
   import dg_timing_pkg::*;
   import dg_regs_pkg::*;

   logic [PAGE_WIDTH-1:0] page;            // target page of pair writes
   logic [TIME_WIDTH-1:0] staged_interval; // held until commit
   logic                  is_pair;
   logic                  is_commit;
   logic [TIME_WIDTH-1:0] clamped;

   assign is_pair   = host_write && (host_addr >= REG_PAIR_0) && (host_addr <= REG_PAIR_8);
   assign is_commit = host_write && (host_addr == REG_COMMIT) && host_data[COMMIT_BIT];
   assign clamped   = (staged_interval < MIN_INTERVAL) ? MIN_INTERVAL : staged_interval;

   // ==============================
   // control registers
   // ==============================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         pair_write      <= 1'b0;
         interval_commit <= 1'b0;
         page            <= '0;
         protocol_select <= '0;
         staged_interval <= DEFAULT_INTERVAL;
      end else begin
         pair_write      <= is_pair;   // one cycle behind host strobe
         interval_commit <= is_commit;
         if (host_write) begin
            case (host_addr)
               REG_INTERVAL: staged_interval <= host_data[INTERVAL_LSB +: TIME_WIDTH];
               REG_PAGE:     page            <= host_data[SELECT_LSB +: PAGE_WIDTH];
               REG_PROTOCOL: protocol_select <= host_data[SELECT_LSB +: PAGE_WIDTH];
               default: ;
            endcase
         end
      end
   end

   // ==============================
   // write payload
   // ==============================
   always_ff @(posedge clk100) begin
      if (is_pair) begin
         pair_page        <= page;
         pair_index       <= ADDR_WIDTH'(host_addr) - ADDR_WIDTH'(REG_PAIR_0);
         pair_value.delay <= host_data[DELAY_LSB +: TIME_WIDTH];
         pair_value.width <= host_data[WIDTH_LSB +: TIME_WIDTH];
      end
      if (is_commit) begin
         interval_value <= clamped; // 1000 cycle floor
      end
   end

endmodule

/* logic/dg_protocol_table.sv */
// protocol page table: four pages of nine delay/width pairs
`timescale 1ns/1ps

module dg_protocol_table (
   input  logic                                 clk100,
   input  logic                                 hps_fpga_reset_n,
   input  logic                                 pair_write,
   input  logic [dg_timing_pkg::PAGE_WIDTH-1:0] pair_page,
   input  logic [3:0]                           pair_index,
   input  dg_timing_pkg::delay_width_t          pair_value,
   input  logic [dg_timing_pkg::PAGE_WIDTH-1:0] read_page,
   output dg_timing_pkg::delay_width_t          page_pairs [dg_timing_pkg::NUM_CHANNELS]
);
   import dg_timing_pkg::*;

   delay_width_t pages [NUM_PROTOCOLS][NUM_CHANNELS];
   logic         index_ok;

   assign index_ok = (pair_index < NUM_CHANNELS); // 9..15 dropped

   // ==============================
   // host side write port
   // ==============================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         pages <= '{default: '0};
      end else if (pair_write && index_ok) begin
         pages[pair_page][pair_index] <= pair_value;
      end
   end

   // ==============================
   // sequencer side page read
   // ==============================
   // whole page out, no read latency
   always_comb begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         page_pairs[c] = pages[read_page][c];
      end
   end

endmodule

/* logic/dg_pulse_channel.sv */
// pulse channel: delay-then-width state machine for one pin
`timescale 1ns/1ps

module dg_pulse_channel (
   input  logic                        clk100,
   input  logic                        hps_fpga_reset_n,
   input  logic                        start, // t0
   input  dg_timing_pkg::delay_width_t pair,
   output logic                        pin
);
   import dg_timing_pkg::*;

   chan_state_e           state;
   logic [TIME_WIDTH-1:0] count;      // cycles left in current phase
   logic [TIME_WIDTH-1:0] width_hold; // width latched at start

   assign pin = (state == CH_WIDTH);

   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         state <= CH_IDLE;
      end else if (start) begin // restart from any state
         if (pair.width == '0) begin
            state <= CH_IDLE;
         end else if (pair.delay == '0) begin
            state <= CH_WIDTH;  // high right after t0
         end else begin
            state <= CH_DELAY;
         end
      end else begin
         case (state)
            CH_DELAY: if (count == '0) state <= CH_WIDTH;
            CH_WIDTH: if (count == '0) state <= CH_IDLE;
            default: ;
         endcase
      end
   end

   // down counter shared by delay and width phases
   always_ff @(posedge clk100) begin
      if (start) begin
         width_hold <= pair.width;
         count      <= (pair.delay == '0) ? pair.width - 1'b1 : pair.delay - 1'b1;
      end else if (state == CH_DELAY && count == '0) begin
         count <= width_hold - 1'b1;
      end else if (state != CH_IDLE) begin
         count <= count - 1'b1;
      end
   end

endmodule

/* logic/dg_regs_pkg.sv */
// host register map enum and host data layout constants
package dg_regs_pkg;

   localparam int HOST_DATA_WIDTH = 64;
   localparam int ADDR_WIDTH      = 4;

   // register opcodes, pair k lives at REG_PAIR_0 + k
   typedef enum logic [ADDR_WIDTH-1:0] {
      REG_INTERVAL = 4'd0,
      REG_PAIR_0   = 4'd1,
      REG_PAIR_1   = 4'd2,
      REG_PAIR_2   = 4'd3,
      REG_PAIR_3   = 4'd4,
      REG_PAIR_4   = 4'd5,
      REG_PAIR_5   = 4'd6,
      REG_PAIR_6   = 4'd7,
      REG_PAIR_7   = 4'd8,
      REG_PAIR_8   = 4'd9,
      REG_PAGE     = 4'd13, // write page for pair registers
      REG_PROTOCOL = 4'd14, // protocol used from next t0
      REG_COMMIT   = 4'd15  // apply staged interval
   } reg_addr_e;

   // bit positions inside host_data
   localparam int INTERVAL_LSB = 0;  // interval in low word
   localparam int DELAY_LSB    = 32; // pair delay in high word
   localparam int WIDTH_LSB    = 0;  // pair width in low word
   localparam int SELECT_LSB   = 0;  // page / protocol number
   localparam int COMMIT_BIT   = 0;
endpackage

/* logic/dg_sequencer.sv */
// pulse sequencer: period counter, t0, protocol latch, t0 count and timestamp
`timescale 1ns/1ps

module dg_sequencer (
   input  logic                                    clk100,
   input  logic                                    hps_fpga_reset_n,
   input  logic                                    interval_commit,
   input  logic [dg_timing_pkg::TIME_WIDTH-1:0]    interval_value,
   input  logic [dg_timing_pkg::PAGE_WIDTH-1:0]    protocol_select,
   input  dg_timing_pkg::delay_width_t             page_pairs [dg_timing_pkg::NUM_CHANNELS],
   output logic [dg_timing_pkg::PAGE_WIDTH-1:0]    read_page,
   output logic [dg_timing_pkg::NUM_CHANNELS-1:0]  pins,
   output logic                                    t0,
   output logic [31:0]                             t0_count,
   output logic [dg_timing_pkg::STAMP_WIDTH-1:0]   t0_timestamp
);
   import dg_timing_pkg::*;

   logic [TIME_WIDTH-1:0]  pending_interval; // last commit
   logic [TIME_WIDTH-1:0]  active_interval;  // in force since last t0
   logic [TIME_WIDTH-1:0]  next_interval;
   logic [TIME_WIDTH-1:0]  phase;            // cycle within period
   logic [STAMP_WIDTH-1:0] clock_counter;    // cycles since reset release
   logic                   fire;             // t0 goes high next cycle

   assign fire = (phase == '0);

   // a commit in the latching cycle still makes it
   assign next_interval = interval_commit ? interval_value : pending_interval;

   // ==============================
   // period and t0
   // ==============================
   always_ff @(posedge clk100) begin
      if (!hps_fpga_reset_n) begin
         pending_interval <= DEFAULT_INTERVAL;
         active_interval  <= DEFAULT_INTERVAL;
         phase            <= '0;
         t0               <= 1'b0;
         read_page        <= '0;
         clock_counter    <= '0;
         t0_count         <= '0;
         t0_timestamp     <= '0;
      end else begin
         clock_counter <= clock_counter + 1'b1;
         t0            <= fire;
         if (interval_commit) pending_interval <= interval_value;
         if (fire) begin
            active_interval <= next_interval;   // settings apply from this t0
            read_page       <= protocol_select;
         end
         phase <= (phase == active_interval - 1'b1) ? '0 : phase + 1'b1;
         if (t0) begin
            t0_count     <= t0_count + 1'b1;
            t0_timestamp <= clock_counter;      // counter value during t0
         end
      end
   end

   // ==============================
   // channels
   // ==============================
   for (genvar k = 0; k < NUM_CHANNELS; k++) begin : chan
      dg_pulse_channel pulse_channel_i (
         .clk100             ( clk100 )
         , .hps_fpga_reset_n ( hps_fpga_reset_n )
         , .start            ( t0 )
         , .pair             ( page_pairs[k] )
         , .pin              ( pins[k] )
      );
   end

endmodule

/* logic/dg_timing_pkg.sv */
// timing dimensions, delay/width pair type, channel state enum
package dg_timing_pkg;

   // ==============================
   // dimensions
   // ==============================
   localparam int NUM_CHANNELS  = 9;  // pulse pins
   localparam int NUM_PROTOCOLS = 4;  // protocol pages
   localparam int PAGE_WIDTH    = 2;  // page index bits
   localparam int TIME_WIDTH    = 32; // delay, width, interval
   localparam int STAMP_WIDTH   = 64; // clock counter, timestamp

   // period limits in clk100 cycles
   localparam logic [TIME_WIDTH-1:0] MIN_INTERVAL     = 32'd1000;   // 10 us floor
   localparam logic [TIME_WIDTH-1:0] DEFAULT_INTERVAL = 32'd100000; // 1 ms

   // ==============================
   // types
   // ==============================
   typedef struct packed {
      logic [TIME_WIDTH-1:0] delay; // cycles from t0 to rising edge
      logic [TIME_WIDTH-1:0] width; // high time, 0 means no pulse
   } delay_width_t;

   typedef enum logic [1:0] {
      CH_IDLE  = 2'd0,
      CH_DELAY = 2'd1,
      CH_WIDTH = 2'd2
   } chan_state_e;

endpackage

/* logic/dg_top.sv */
// top level: host decoder, protocol table, pulse sequencer
`timescale 1ns/1ps

module dg_top (
   input  logic                                    clk100,
   input  logic                                    hps_fpga_reset_n,
   input  logic                                    host_write,
   input  dg_regs_pkg::reg_addr_e                  host_addr,
   input  logic [dg_regs_pkg::HOST_DATA_WIDTH-1:0] host_data,
   output logic [dg_timing_pkg::NUM_CHANNELS-1:0]  pins,
   output logic                                    t0,
   output logic [31:0]                             t0_count,
   output logic [dg_timing_pkg::STAMP_WIDTH-1:0]   t0_timestamp
);
   import dg_timing_pkg::*;

   logic                  pair_write;
   logic [PAGE_WIDTH-1:0] pair_page;
   logic [3:0]            pair_index;
   delay_width_t          pair_value;
   logic [PAGE_WIDTH-1:0] protocol_select; // host setpoint
   logic                  interval_commit;
   logic [TIME_WIDTH-1:0] interval_value;  // already clamped
   logic [PAGE_WIDTH-1:0] read_page;       // protocol in force
   delay_width_t          page_pairs [NUM_CHANNELS];

   dg_host_port host_port_i (
      .clk100, .hps_fpga_reset_n, .host_write, .host_addr, .host_data
      , .pair_write, .pair_page, .pair_index, .pair_value
      , .protocol_select, .interval_commit, .interval_value
   );

   dg_protocol_table protocol_table_i (
      .clk100, .hps_fpga_reset_n
      , .pair_write, .pair_page, .pair_index, .pair_value
      , .read_page, .page_pairs
   );

   dg_sequencer sequencer_i (
      .clk100, .hps_fpga_reset_n
      , .interval_commit, .interval_value, .protocol_select, .page_pairs
      , .read_page, .pins, .t0, .t0_count, .t0_timestamp
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run the testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module dg_tb -f flist.f \
   --Mdir obj_dir -o dg_sim > build.log 2>&1 \
   && ./obj_dir/dg_sim > sim.log 2>&1 \
   && cat sim.log \
   && ! grep -q "Some tests failed" sim.log \
   && echo "simulation passed" \
   || { cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

/* testbench/dg_checker.sv */
// concurrent assertions on dg_top ports and their bind
`timescale 1ns/1ps

module dg_checker (
   input logic                                   clk100,
   input logic                                   hps_fpga_reset_n,
   input logic [dg_timing_pkg::NUM_CHANNELS-1:0] pins,
   input logic                                   t0,
   input logic [31:0]                            t0_count
);

   // ==============================
   // reset
   // ==============================
   // outputs quiet once reset has been seen for a full cycle
   reset_quiet: assert property (@(posedge clk100)
      (!hps_fpga_reset_n && $past(!hps_fpga_reset_n)) |-> (pins == '0 && !t0))
      else $error("pins or t0 active while reset is held");

   // ==============================
   // t0 behavior
   // ==============================
   t0_single: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      t0 |=> !t0)
      else $error("t0 high for two cycles in a row");

   t0_count_step: assert property (@(posedge clk100) disable iff (!hps_fpga_reset_n)
      t0 |=> (t0_count == $past(t0_count) + 32'd1))
      else $error("t0_count did not step by one after t0");

endmodule

bind dg_top dg_checker checker_i (.clk100, .hps_fpga_reset_n, .pins, .t0, .t0_count);

/* testbench/dg_stimulus.txt */
# W addr data (hex, data = delay[63:32] width[31:0]) | T | P period | E channel delay width
# P measures up to the next t0; E lines apply to the next P (decimal)
T                          first t0 after reset
W 0 00000000000000c8       stage 200
W f 0000000000000001       commit, clamps to 1000
P 100000                   default period still in force
P 1000
W 0 00000000000009c4       stage 2500
W f 0000000000000001
P 1000                     commit waits for the next t0
P 2500
W 1 0000000000000005       page 0 ch0 d=0 w=5
W 2 0000000a00000014       ch1 d=10 w=20
W 3 0000006400000000       ch2 width 0
W 4 00000960000001f4       ch3 d=2400 w=500 runs past next t0
W 5 0000000100000001       ch4 d=1 w=1
P 2500                     pairs not latched yet
E 0 0 5
E 1 10 20
E 2 100 0
E 3 2400 500
E 4 1 1
P 2500
W d 0000000000000002       page 2 writes
W 1 0000000300000004
W 2 0000000000000002
W 3 000001f400000032
W 4 0000000000000000
W 5 0000003200000000
W 9 0000000700000008
W e 0000000000000002       protocol 2 from next t0
E 0 0 5
E 1 10 20
E 3 2400 500
P 2500                     page 0 still active
E 0 3 4
E 1 0 2
E 2 500 50
E 3 0 0
E 4 50 0
E 8 7 8
P 2500
W d 0000000000000001       page 1 writes while protocol 2 runs
W 1 0000000000000064
W 9 0000000000000064
P 2500
E 0 3 4
E 8 7 8
P 2500

/* testbench/dg_tb.sv */
// testbench: clock, reset, stimulus file interpreter, checks, watchdog, summary
`timescale 1ns/1ps

module dg_tb;
   import dg_timing_pkg::*;
   import dg_regs_pkg::*;

   logic                       clk100 = 1'b0;
   logic                       hps_fpga_reset_n;
   logic                       host_write;
   reg_addr_e                  host_addr;
   logic [HOST_DATA_WIDTH-1:0] host_data;
   logic [NUM_CHANNELS-1:0]    pins;
   logic                       t0;
   logic [31:0]                t0_count;
   logic [STAMP_WIDTH-1:0]     t0_timestamp;

   logic [7:0]  op_q [$];        // parsed stimulus commands
   logic [63:0] arg1_q [$];
   logic [63:0] arg2_q [$];
   logic [63:0] arg3_q [$];
   int          line_q [$];
   logic [63:0] period_sum = '0; // for the watchdog limit
   int          exp_ch [$];      // pulses due in the next measured period
   logic [63:0] exp_delay [$];
   logic [63:0] exp_width [$];

   bit          have_t0 = 1'b0;
   bit          t0_now = 1'b0;
   bit          period_done = 1'b0;
   int          offset = 0;      // cycles since last t0
   int          t0_seen = 0;
   logic [63:0] last_period = '0;
   logic [63:0] prev_stamp = '0;
   int          first_hi [NUM_CHANNELS];
   int          last_hi [NUM_CHANNELS];
   int          hi_count [NUM_CHANNELS];
   int          done_first [NUM_CHANNELS];
   int          done_last [NUM_CHANNELS];
   int          done_count [NUM_CHANNELS];
   int          check_count = 0;
   int          error_count = 0;

   dg_top dut0 (
      .clk100, .hps_fpga_reset_n, .host_write, .host_addr, .host_data,
      .pins, .t0, .t0_count, .t0_timestamp
   );

   always #4 clk100 = ~clk100; // 8 ns period

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("Error %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   // ==============================
   // per-cycle sampling
   // ==============================
   task automatic step_cycle();
      @(negedge clk100); // outputs settled since the rising edge
      t0_now = t0;
      if (have_t0) begin
         offset++;
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (pins[c]) begin
               if (hi_count[c] == 0) first_hi[c] = offset;
               last_hi[c] = offset;
               hi_count[c]++;
            end
         end
         if (offset == 1) begin // counters settle one cycle after t0
            compare_value("t0_count step", t0_seen, t0_count);
            if (t0_seen > 1) begin
               compare_value("t0_timestamp step", last_period, t0_timestamp - prev_stamp);
            end
            prev_stamp = t0_timestamp;
         end
      end
      if (t0) begin
         if (!have_t0) begin
            compare_value("first t0 count", 0, t0_count);
            compare_value("first t0 stamp", 0, t0_timestamp);
            compare_value("first t0 pins", 0, pins);
         end else begin
            last_period = offset;
            done_first  = first_hi;
            done_last   = last_hi;
            done_count  = hi_count;
            period_done = 1'b1;
         end
         have_t0  = 1'b1;
         offset   = 0;
         first_hi = '{default: 0};
         last_hi  = '{default: 0};
         hi_count = '{default: 0};
         t0_seen++;
      end
   endtask

   task automatic apply_reset();
      hps_fpga_reset_n = 1'b0;
      for (int i = 0; i < 10; i++) begin
         @(negedge clk100);
         compare_value("reset pins", 0, pins);
         compare_value("reset t0", 0, t0);
         compare_value("reset t0_count", 0, t0_count);
         compare_value("reset t0_timestamp", 0, t0_timestamp);
      end
      hps_fpga_reset_n = 1'b1;
   endtask

   task automatic host_write_op(input logic [3:0] addr, input logic [63:0] data);
      int unsigned gap;
      gap = $urandom % 4; // idle cycles before the strobe
      repeat (gap) step_cycle();
      host_write = 1'b1;
      host_addr  = reg_addr_e'(addr);
      host_data  = data;
      step_cycle();
      host_write = 1'b0;
   endtask

   task automatic wait_t0();
      do step_cycle(); while (!t0_now);
   endtask

   // runs to the next t0, then checks the period and queued pulses
   task automatic measure_period(input int line, input logic [63:0] expected);
      logic [63:0] d;
      logic [63:0] w;
      logic [63:0] e_first;
      logic [63:0] e_last;
      int          ch;
      period_done = 1'b0;
      while (!period_done) step_cycle();
      compare_value($sformatf("line %0d period", line), expected, last_period);
      for (int i = 0; i < exp_ch.size(); i++) begin
         ch      = exp_ch[i];
         d       = exp_delay[i];
         w       = exp_width[i];
         e_first = '0;
         e_last  = '0;
         if (w != 0 && d + 1 <= expected) begin
            e_first = d + 1;
            e_last  = (d + w < expected) ? d + w : expected; // cut at next t0
         end
         compare_value($sformatf("line %0d ch%0d first high", line, ch), e_first, done_first[ch]);
         compare_value($sformatf("line %0d ch%0d last high", line, ch), e_last, done_last[ch]);
         compare_value($sformatf("line %0d ch%0d high cycles", line, ch),
                       (e_first == 0) ? 0 : e_last - d, done_count[ch]);
      end
      exp_ch.delete();
      exp_delay.delete();
      exp_width.delete();
   endtask

   // ==============================
   // stimulus file
   // ==============================
   task automatic load_stimulus();
      int          fd;
      int          lineno;
      string       line;
      logic [7:0]  op;
      logic [63:0] a1;
      logic [63:0] a2;
      logic [63:0] a3;
      bit          ok;
      lineno = 0;
      fd = $fopen("testbench/dg_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file testbench/dg_stimulus.txt");
         error_count++;
         return;
      end
      while ($fgets(line, fd) > 0) begin
         lineno++;
         a1 = '0;
         a2 = '0;
         a3 = '0;
         if ($sscanf(line, " %c", op) == 1 && op != "#") begin
            case (op)
               "W": ok = ($sscanf(line, " %c %h %h", op, a1, a2) == 3);
               "P": ok = ($sscanf(line, " %c %d", op, a1) == 2);
               "E": ok = ($sscanf(line, " %c %d %d %d", op, a1, a2, a3) == 4);
               "T": ok = 1'b1;
               default: ok = 1'b0;
            endcase
            if (!ok) begin
               $display("stimulus line %0d is not a known command", lineno);
               error_count++;
            end else begin
               op_q.push_back(op);
               arg1_q.push_back(a1);
               arg2_q.push_back(a2);
               arg3_q.push_back(a3);
               line_q.push_back(lineno);
               if (op == "P") period_sum += a1;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic watchdog(input logic [63:0] limit_ns);
      #(limit_ns);
      $display("run timed out after %0d ns with %0d errors", limit_ns, error_count);
      $display("Some tests failed");
      $finish;
   endtask

   initial begin
      hps_fpga_reset_n = 1'b0;
      host_write       = 1'b0;
      host_addr        = REG_INTERVAL;
      host_data        = '0;
      void'($urandom(41665));
      load_stimulus();
      fork
         watchdog((3 * period_sum + 10) * 8); // reset is 10 cycles
      join_none
      apply_reset();
      for (int i = 0; i < op_q.size(); i++) begin
         case (op_q[i])
            "W": host_write_op(4'(arg1_q[i]), arg2_q[i]);
            "T": wait_t0();
            "P": measure_period(line_q[i], arg1_q[i]);
            "E": begin
               exp_ch.push_back(int'(arg1_q[i]));
               exp_delay.push_back(arg2_q[i]);
               exp_width.push_back(arg3_q[i]);
            end
            default: ;
         endcase
      end
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
